// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the simulation ends in $fatal.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_ahb_ram \
    -f tb.f \
    && ./obj_dir/Vtb_ahb_ram \
    || { echo "run.sh: build or simulation returned an error" >&2; exit 1; }

// File: source/ahb_pkg.sv
package ahb_pkg;

    // Byte address as driven by the manager on HADDR.
    typedef logic [31:0] haddr_t;

    // One bus data word on HWDATA or HRDATA.
    // Byte 0 sits in bits 7:0 and belongs to the lowest address.
    typedef logic [31:0] hdata_t;

    // Transfer type.
    // The codes are the HTRANS macros of the settings header.
    typedef logic [1:0] htrans_t;

    // Transfer size.
    // The value is the log2 of the number of bytes moved.
    typedef logic [2:0] hsize_t;

endpackage

// File: source/ahb_ram_ctrl.sv
`timescale 1ns/1ps
`include "ahb_ram_settings.svh"

module ahb_ram_ctrl import ahb_pkg::*, mem_pkg::*; (
    input  logic      HCLK,
    input  logic      HRESETn,
    input  logic      HSEL,
    input  haddr_t    HADDR,
    input  htrans_t   HTRANS,
    input  logic      HWRITE,
    input  hsize_t    HSIZE,
    output logic      HREADY,
    output lane_cmd_t lane_cmd
);

    // ACCESS is normal zero-wait operation.
    // REREAD is the single stall cycle after a read-after-write collision.
    typedef enum logic [0:0] {
        ACCESS,
        REREAD
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic       trans_valid;
    logic       accept;
    logic       read_req;
    logic       write_req;
    word_addr_t req_word;
    byte_mask_t req_mask;
    logic       hazard;

    logic       write_en_q;
    byte_mask_t write_mask_q;
    word_addr_t write_addr_q;
    word_addr_t reread_addr_q;

    // BUSY and IDLE carry no transfer.
    assign trans_valid = HSEL && (HTRANS == `HTRANS_NONSEQ || HTRANS == `HTRANS_SEQ);
    assign accept      = trans_valid && HREADY;
    assign read_req    = accept && !HWRITE;
    assign write_req   = accept && HWRITE;

    assign req_word = HADDR[`AHB_RAM_WORD_ADDR_BITS+1:2];

    // Byte lanes touched by the transfer.
    // Transfers are assumed aligned to their size, as AHB requires.
    always_comb begin
        case (HSIZE)
            `HSIZE_1: req_mask = byte_mask_t'(4'b0001 << HADDR[1:0]);
            `HSIZE_2: req_mask = HADDR[1] ? 4'b1100 : 4'b0011;
            `HSIZE_4: req_mask = 4'b1111;
            default:  req_mask = 4'b0000;
        endcase
    end

    // A read in the data phase of a write to the same word would see the old bytes,
    // so the read is held back and issued again one cycle later.
    assign hazard = read_req && write_en_q && (req_word == write_addr_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ACCESS: begin
                if (hazard) begin
                    state_d = REREAD;
                end
            end
            REREAD: begin
                state_d = ACCESS;
            end
            default: begin
                state_d = ACCESS;
            end
        endcase
    end

    assign HREADY = (state_q == ACCESS);

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state_q      <= ACCESS;
            write_en_q   <= 1'b0;
            write_mask_q <= '0;
        end else begin
            state_q      <= state_d;
            write_en_q   <= write_req;
            write_mask_q <= write_req ? req_mask : '0;
        end
    end

    // Write address waits for HWDATA in the data phase.
    always_ff @(posedge HCLK) begin
        if (write_req) begin
            write_addr_q <= req_word;
        end
        if (hazard) begin
            reread_addr_q <= req_word;
        end
    end

    always_comb begin
        lane_cmd.write_en   = write_en_q;
        lane_cmd.write_addr = write_addr_q;
        lane_cmd.write_mask = write_mask_q;
        if (state_q == REREAD) begin
            lane_cmd.read_en   = 1'b1;
            lane_cmd.read_addr = reread_addr_q;
        end else begin
            lane_cmd.read_en   = read_req && !hazard;
            lane_cmd.read_addr = req_word;
        end
    end

    // A collision costs exactly one wait state.
    single_stall_a: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !HREADY |=> HREADY
    ) else $error("HREADY low for more than one cycle");

    mask_idle_a: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !lane_cmd.write_en |-> lane_cmd.write_mask == '0
    ) else $error("write_mask set without write_en");

    // During the stall only the held read may reach the lanes.
    reread_held_a: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        hazard |=> !accept && lane_cmd.read_en && lane_cmd.read_addr == $past(req_word)
    ) else $error("REREAD cycle did not repeat the stalled read");

endmodule

// File: source/ahb_ram_settings.svh
`ifndef AHB_RAM_SETTINGS_SVH
`define AHB_RAM_SETTINGS_SVH

// Number of word-address bits of the RAM.
// Ten bits give 1024 words, which is 4 KiB of storage.
`define AHB_RAM_WORD_ADDR_BITS 10

// AHB-Lite transfer types carried on HTRANS.
`define HTRANS_IDLE   2'b00
`define HTRANS_BUSY   2'b01
`define HTRANS_NONSEQ 2'b10
`define HTRANS_SEQ    2'b11

// AHB-Lite transfer sizes carried on HSIZE.
// Only byte, halfword and word transfers reach the memory.
// Larger codes produce an empty byte mask.
`define HSIZE_1 3'b000
`define HSIZE_2 3'b001
`define HSIZE_4 3'b010

`endif

// File: source/ahb_ram_top.sv
`timescale 1ns/1ps

module ahb_ram_top import ahb_pkg::*, mem_pkg::*; (
    input  logic    HCLK,
    input  logic    HRESETn,
    input  logic    HSEL,
    input  haddr_t  HADDR,
    input  htrans_t HTRANS,
    input  logic    HWRITE,
    input  hsize_t  HSIZE,
    input  hdata_t  HWDATA,
    output hdata_t  HRDATA,
    output logic    HREADY
);

    lane_cmd_t  lane_cmd;
    lane_byte_t lane_rdata [4];

    ahb_ram_ctrl ctrl_i (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .HSEL     (HSEL),
        .HADDR    (HADDR),
        .HTRANS   (HTRANS),
        .HWRITE   (HWRITE),
        .HSIZE    (HSIZE),
        .HREADY   (HREADY),
        .lane_cmd (lane_cmd)
    );

    // Lane i holds byte i of every word.
    for (genvar i = 0; i < 4; i++) begin : g_lane
        logic lane_write_en;

        assign lane_write_en = lane_cmd.write_en && lane_cmd.write_mask[i];

        ram_byte_lane lane_i (
            .HCLK       (HCLK),
            .read_en    (lane_cmd.read_en),
            .read_addr  (lane_cmd.read_addr),
            .write_en   (lane_write_en),
            .write_addr (lane_cmd.write_addr),
            .wdata      (HWDATA[8*i +: 8]),
            .rdata      (lane_rdata[i])
        );

        assign HRDATA[8*i +: 8] = lane_rdata[i];
    end

endmodule

// File: source/mem_pkg.sv
`include "ahb_ram_settings.svh"

package mem_pkg;

    // Index of one 32-bit word inside the RAM.
    // It is taken from HADDR bits 2 upward.
    typedef logic [`AHB_RAM_WORD_ADDR_BITS-1:0] word_addr_t;

    // One enable per byte lane, bit 0 for the lowest address byte.
    typedef logic [3:0] byte_mask_t;

    // The data held by one byte lane.
    typedef logic [7:0] lane_byte_t;

    // Everything the lanes need for one clock cycle.
    // The read fields act in the address phase of a read.
    // The write fields act in the data phase of a write, together with HWDATA.
    typedef struct packed {
        logic       read_en;
        word_addr_t read_addr;
        logic       write_en;
        word_addr_t write_addr;
        byte_mask_t write_mask;
    } lane_cmd_t;

endpackage

// File: source/ram_byte_lane.sv
`timescale 1ns/1ps
`include "ahb_ram_settings.svh"

module ram_byte_lane import mem_pkg::*; (
    input  logic       HCLK,
    input  logic       read_en,
    input  word_addr_t read_addr,
    input  logic       write_en,
    input  word_addr_t write_addr,
    input  lane_byte_t wdata,
    output lane_byte_t rdata
);

    localparam int DEPTH = 1 << `AHB_RAM_WORD_ADDR_BITS;

    lane_byte_t mem [DEPTH];

    always_ff @(posedge HCLK) begin
        if (write_en) begin
            mem[write_addr] <= wdata;
        end
    end

    // Registered read port.
    // rdata keeps the last word read until the next read.
    always_ff @(posedge HCLK) begin
        if (read_en) begin
            rdata <= mem[read_addr];
        end
    end

    // The controller's stall keeps a read away from the word written in the same cycle.
    no_collision_a: assert property (
        @(posedge HCLK)
        !(read_en && write_en && read_addr == write_addr)
    ) else $error("read and write of the same word in one cycle");

endmodule

// File: tb.f
+incdir+source
+incdir+verif
source/ahb_pkg.sv
source/mem_pkg.sv
source/ram_byte_lane.sv
source/ahb_ram_ctrl.sv
source/ahb_ram_top.sv
verif/tb_clock_gen.sv
verif/tb_ahb_ram.sv

// File: verif/tb_ahb_ram_model.svh
`ifndef TB_AHB_RAM_MODEL_SVH
`define TB_AHB_RAM_MODEL_SVH

// Byte image of the RAM, indexed by byte address.
lane_byte_t ref_mem [1 << (`AHB_RAM_WORD_ADDR_BITS + 2)];

function automatic word_addr_t word_of(input haddr_t addr);
    return addr[`AHB_RAM_WORD_ADDR_BITS+1:2];
endfunction

// A transfer of 2**HSIZE bytes covers the aligned group of lanes that holds HADDR.
// Each byte travels on the lane of its own address.
// Sizes above a word cover no lane at all.
task automatic model_write(input haddr_t addr, input hsize_t size, input hdata_t data);
    int nbytes;
    int first;
    int lane;
    if (size <= `HSIZE_4) begin
        nbytes = 1 << size;
        first  = int'(addr[1:0]) - (int'(addr[1:0]) % nbytes);
        for (lane = first; lane < first + nbytes; lane++) begin
            ref_mem[{word_of(addr), 2'(lane)}] = data[8*lane +: 8];
        end
    end
endtask

function automatic hdata_t model_read_word(input haddr_t addr);
    hdata_t word;
    int     lane;
    for (lane = 0; lane < 4; lane++) begin
        word[8*lane +: 8] = ref_mem[{word_of(addr), 2'(lane)}];
    end
    return word;
endfunction

// A read stalls when its address phase meets the data phase of a write to the same word.
function automatic logic predict_stall(input logic read_accepted, input haddr_t read_addr,
                                       input logic write_pending, input haddr_t write_addr);
    return read_accepted && write_pending && (word_of(read_addr) == word_of(write_addr));
endfunction

task automatic check_value(input string name, input hdata_t got, input hdata_t expected);
    if (got !== expected) begin
        $display("Fail: %s is 0x%08h, expected 0x%08h", name, got, expected);
        $display("Simulation failed");
        $fatal(1, "value mismatch on %s", name);
    end
endtask

`endif

// File: verif/tb_ahb_ram.sv
`timescale 1ns/1ps
`include "ahb_ram_settings.svh"

module tb_ahb_ram import ahb_pkg::*, mem_pkg::*;;

    localparam int SEED             = 60711;
    localparam int RESET_CYCLES     = 4;
    localparam int FILL_WORDS       = 1 << `AHB_RAM_WORD_ADDR_BITS;
    localparam int BASIC_PAIRS      = 16;
    localparam int PARTIAL_WORDS    = 4;
    localparam int HAZARD_PAIRS     = 8;
    localparam int NOSTALL_ROUNDS   = 8;
    localparam int IGNORED_WORDS    = 4;
    localparam int RANDOM_TRANSFERS = 400;
    localparam int RANDOM_SPAN      = 32;
    localparam int TEST_COUNT       = 6;
    localparam int TOTAL_TRANSFERS  = FILL_WORDS + 2 * BASIC_PAIRS + 13 * PARTIAL_WORDS
                                    + 2 * HAZARD_PAIRS + 3 * NOSTALL_ROUNDS
                                    + 6 * IGNORED_WORDS + RANDOM_TRANSFERS + TEST_COUNT + 1;
    localparam int CYCLE_LIMIT      = 3 * TOTAL_TRANSFERS + RESET_CYCLES;
    localparam hsize_t HSIZE_8      = 3'b011;

    logic    HCLK;
    logic    HRESETn;
    logic    HSEL;
    haddr_t  HADDR;
    htrans_t HTRANS;
    logic    HWRITE;
    hsize_t  HSIZE;
    hdata_t  HWDATA;
    hdata_t  HRDATA;
    logic    HREADY;

    // Transfer in its data phase, as seen by the comparing process.
    logic   dp_valid      = 1'b0;
    logic   dp_write      = 1'b0;
    haddr_t dp_addr       = '0;
    hsize_t dp_size       = '0;
    logic   stall_now     = 1'b0;
    int     stall_count   = 0;
    int     reads_issued  = 0;
    int     reads_checked = 0;
    int     cycle_count   = 0;
    hdata_t next_hwdata   = '0;

    `include "tb_ahb_ram_model.svh"

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen_i (
        .HCLK    (HCLK),
        .HRESETn (HRESETn)
    );

    ahb_ram_top dut_i (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .HSEL    (HSEL),
        .HADDR   (HADDR),
        .HTRANS  (HTRANS),
        .HWRITE  (HWRITE),
        .HSIZE   (HSIZE),
        .HWDATA  (HWDATA),
        .HRDATA  (HRDATA),
        .HREADY  (HREADY)
    );

    // HWDATA of the previous transfer goes out with the next address phase.
    task automatic drive_transfer(input logic sel, input htrans_t trans, input logic write,
                                  input hsize_t size, input haddr_t addr, input hdata_t wdata);
        @(posedge HCLK);
        HSEL   <= sel;
        HTRANS <= trans;
        HWRITE <= write;
        HSIZE  <= size;
        HADDR  <= addr;
        HWDATA <= next_hwdata;
        next_hwdata = wdata;
        @(negedge HCLK);
        while (!HREADY) begin
            @(negedge HCLK);
        end
    endtask

    task automatic write_bus(input haddr_t addr, input hsize_t size, input hdata_t data);
        drive_transfer(1'b1, `HTRANS_NONSEQ, 1'b1, size, addr, data);
    endtask

    task automatic read_bus(input haddr_t addr, input hsize_t size);
        reads_issued++;
        drive_transfer(1'b1, `HTRANS_NONSEQ, 1'b0, size, addr, $urandom());
    endtask

    task automatic idle_bus();
        drive_transfer(1'b0, `HTRANS_IDLE, 1'b0, `HSIZE_4, '0, $urandom());
    endtask

    function automatic hdata_t fill_word(input int idx);
        return (hdata_t'(idx) * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
    endfunction

    function automatic haddr_t random_addr(input hsize_t size, input int span);
        int word;
        int offset;
        int nbytes;
        nbytes = 1 << size;
        word   = int'($urandom_range(span - 1, 0));
        offset = int'($urandom_range(3, 0));
        offset = offset - (offset % nbytes);
        return haddr_t'(word * 4 + offset);
    endfunction

    // Follows the bus at mid-cycle, when every signal has settled.
    always @(negedge HCLK) begin
        if (HRESETn) begin
            check_value("HREADY", 32'(HREADY), 32'(!stall_now));
            if (stall_now) begin
                stall_now = 1'b0;
                stall_count++;
            end else begin
                if (dp_valid && dp_write) begin
                    model_write(dp_addr, dp_size, HWDATA);
                end else if (dp_valid) begin
                    check_value("HRDATA", HRDATA, model_read_word(dp_addr));
                    reads_checked++;
                end
                if (HSEL && (HTRANS == `HTRANS_NONSEQ || HTRANS == `HTRANS_SEQ)) begin
                    stall_now = predict_stall(!HWRITE, HADDR, dp_valid && dp_write, dp_addr);
                    dp_valid  = 1'b1;
                    dp_write  = HWRITE;
                    dp_addr   = HADDR;
                    dp_size   = HSIZE;
                end else begin
                    dp_valid = 1'b0;
                end
            end
        end
    end

    always @(posedge HCLK) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the test did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        haddr_t addr;
        hsize_t size;
        haddr_t basic_addr [BASIC_PAIRS];
        int     i;
        int     k;
        int     stalls_before;
        void'($urandom(SEED));
        HSEL   = 1'b0;
        HADDR  = '0;
        HTRANS = `HTRANS_IDLE;
        HWRITE = 1'b0;
        HSIZE  = `HSIZE_4;
        HWDATA = '0;
        wait (HRESETn === 1'b1);
        @(negedge HCLK);
        check_value("HREADY", 32'(HREADY), 32'd1);

        // Every word gets a known value first.
        for (i = 0; i < FILL_WORDS; i++) begin
            write_bus(haddr_t'(i * 4), `HSIZE_4, fill_word(i));
        end

        for (i = 0; i < BASIC_PAIRS; i++) begin
            basic_addr[i] = random_addr(`HSIZE_4, FILL_WORDS);
            write_bus(basic_addr[i], `HSIZE_4, $urandom());
        end
        for (i = 0; i < BASIC_PAIRS; i++) begin
            read_bus(basic_addr[i], `HSIZE_4);
        end
        idle_bus();

        for (i = 0; i < PARTIAL_WORDS; i++) begin
            addr = random_addr(`HSIZE_4, FILL_WORDS);
            write_bus(addr, `HSIZE_4, $urandom());
            for (k = 0; k < 4; k++) begin
                write_bus(addr | haddr_t'(k), `HSIZE_1, $urandom());
                read_bus(addr, `HSIZE_4);
            end
            for (k = 0; k < 2; k++) begin
                write_bus(addr | haddr_t'(2 * k), `HSIZE_2, $urandom());
                read_bus(addr, `HSIZE_4);
            end
        end
        idle_bus();

        // A read right behind a write to the same word costs one wait state.
        stalls_before = stall_count;
        for (i = 0; i < HAZARD_PAIRS; i++) begin
            size = hsize_t'($urandom_range(2, 0));
            addr = random_addr(size, FILL_WORDS);
            write_bus(addr, size, $urandom());
            read_bus(addr & ~32'h3, `HSIZE_4);
        end
        idle_bus();
        check_value("stall_count", 32'(stall_count - stalls_before), 32'(HAZARD_PAIRS));

        stalls_before = stall_count;
        for (i = 0; i < NOSTALL_ROUNDS; i++) begin
            addr = random_addr(`HSIZE_4, FILL_WORDS);
            write_bus(addr, `HSIZE_4, $urandom());
            read_bus(addr ^ 32'h4, `HSIZE_4);
            read_bus(addr, `HSIZE_4);
        end
        idle_bus();
        check_value("stall_count", 32'(stall_count - stalls_before), 32'd0);

        for (i = 0; i < IGNORED_WORDS; i++) begin
            addr = random_addr(`HSIZE_4, FILL_WORDS);
            drive_transfer(1'b0, `HTRANS_NONSEQ, 1'b1, `HSIZE_4, addr, $urandom());
            read_bus(addr, `HSIZE_4);
            drive_transfer(1'b1, `HTRANS_IDLE, 1'b1, `HSIZE_4, addr, $urandom());
            read_bus(addr, `HSIZE_4);
            drive_transfer(1'b1, `HTRANS_NONSEQ, 1'b1, HSIZE_8, addr, $urandom());
            read_bus(addr, `HSIZE_4);
        end
        idle_bus();

        // A narrow address window makes same-word collisions likely.
        for (i = 0; i < RANDOM_TRANSFERS; i++) begin
            size = hsize_t'($urandom_range(2, 0));
            addr = random_addr(size, RANDOM_SPAN);
            if ($urandom_range(1, 0) == 1) begin
                write_bus(addr, size, $urandom());
            end else begin
                read_bus(addr, size);
            end
        end
        idle_bus();
        idle_bus();

        if (reads_checked != reads_issued) begin
            $display("Fail: reads_checked is 0x%08h, expected 0x%08h",
                     reads_checked, reads_issued);
            $display("Simulation failed");
            $fatal(1, "reads were lost");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic HCLK,
    output logic HRESETn
);

    initial begin
        HCLK = 1'b0;
        forever begin
            #(PERIOD_NS / 2) HCLK = ~HCLK;
        end
    end

    // The DUT sees HRESETn low on RESET_CYCLES rising edges.
    initial begin
        HRESETn = 1'b0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        HRESETn <= 1'b1;
    end

endmodule
